//--- compile.f
+incdir+bench
verilog/pix_pkg.sv
verilog/conv_pkg.sv
verilog/rgb_skid.sv
verilog/rgb2y_matrix.sv
verilog/rgb2y_out_pack.sv
verilog/rgb2y_top.sv
bench/tb_rgb2y.sv

//--- run.sh
#!/bin/sh
# build the RGB to luma testbench with Verilator and run it
# the exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_rgb2y -o sim_rgb2y
./obj_dir/sim_rgb2y

//--- bench/tb_model.svh
// testbench helpers for the RGB to luma converter
// random source, reference luma model and value compare

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// galois lfsr state, one step per bit handed out
logic [31:0] lfsr;

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  int          i;
  v = '0;
  for (i = 0; i < n; i++) begin
    v    = {v[30:0], lfsr[0]};
    // taps for x^32 + x^22 + x^2 + x + 1
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
  end
  return v;
endfunction

// expected output word for one input pixel
function automatic y_pix_t model_y(input rgb_pix_t p, input logic byp, input clip_cfg_t c);
  int     sum;
  int     yw;
  int     y;
  y_pix_t res;
  sum = int'(p.r) * int'(COEF_R) + int'(p.g) * int'(COEF_G) + int'(p.b) * int'(COEF_B);
  // 12-bit wide luma
  yw  = sum >> COEF_SHIFT;
  if (byp) begin
    // plain truncation, window ignored
    y = yw >> 2;
  end else begin
    y = (yw + 2) >> 2;
    if (c.en) begin
      // above hi always gives hi, even for an inverted window
      if (y > int'(c.hi)) begin
        y = int'(c.hi);
      end else if (y < int'(c.lo)) begin
        y = int'(c.lo);
      end
    end
  end
  res.sb = p.sb;
  res.y  = PIX_W'(y);
  return res;
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp) begin
    $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    abort_run();
  end
endtask

`endif

//--- bench/tb_rgb2y.sv
// testbench for the RGB to luma converter
// random pixels against a reference model, with back-pressure and freeze

`default_nettype none

module tb_rgb2y
  import pix_pkg::*;
  import conv_pkg::*;
;

  localparam int WAIT_LIMIT = 200;

  logic        clk;
  logic        rst;
  logic        en;
  logic        in_valid;
  rgb_pix_t    in_pix;
  logic        in_ready;
  logic        out_valid;
  y_pix_t      out_pix;
  logic        out_ready;
  logic        bypass;
  clip_cfg_t   clip;
  logic [31:0] drop_cnt;
  logic [31:0] stall_cnt;

  // monitor state
  y_pix_t      exp_q[$];
  y_pix_t      exp_w;
  logic        in_acc = 1'b0;
  int          drop_ref = 0;
  int          stall_ref = 0;
  logic        en_last = 1'b1;
  logic        ov_last = 1'b0;
  y_pix_t      op_last = '0;
  logic [31:0] dc_last = '0;
  logic [31:0] sc_last = '0;

  `include "tb_model.svh"

  rgb2y_top dut (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .in_valid  (in_valid),
    .in_pix    (in_pix),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_pix   (out_pix),
    .out_ready (out_ready),
    .bypass    (bypass),
    .clip      (clip),
    .drop_cnt  (drop_cnt),
    .stall_cnt (stall_cnt)
  );

  always #2 clk = ~clk;

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first failure");
  endtask

  // ------------------------------------------------------------------------
  // monitor, samples at the falling edge where everything is stable
  // ------------------------------------------------------------------------

  always @(negedge clk) begin
    if (!rst) begin
      // output side first, the queue head is always the oldest word
      if (en && out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("output word appeared with no matching input word");
          abort_run();
        end
        exp_w = exp_q.pop_front();
        check_eq(32'(out_pix), 32'(exp_w), "output word");
        if (clip.en && !bypass && clip.lo <= clip.hi) begin
          check_eq(32'(out_pix.y >= clip.lo && out_pix.y <= clip.hi), 32'd1, "clip window");
        end
      end
      // between words the output carries zero
      if (!out_valid) begin
        check_eq(32'(out_pix), 32'd0, "out_pix while idle");
      end
      in_acc = en && in_valid && in_ready;
      if (in_acc) begin
        exp_q.push_back(model_y(in_pix, bypass, clip));
      end
      if (en && in_valid && !in_ready) begin
        drop_ref++;
      end
      if (en && out_valid && !out_ready) begin
        stall_ref++;
      end
      // in_ready stays low while frozen
      if (!en) begin
        check_eq(32'(in_ready), 32'd0, "in_ready while frozen");
      end
      // nothing moves across an edge taken with en low
      if (!en_last) begin
        check_eq(32'(out_valid), 32'(ov_last), "out_valid while frozen");
        check_eq(32'(out_pix), 32'(op_last), "out_pix while frozen");
        check_eq(drop_cnt, dc_last, "drop_cnt while frozen");
        check_eq(stall_cnt, sc_last, "stall_cnt while frozen");
      end
      en_last = en;
      ov_last = out_valid;
      op_last = out_pix;
      dc_last = drop_cnt;
      sc_last = stall_cnt;
    end
  end

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------

  // corner pixels first when asked, random ones after
  function automatic rgb_pix_t make_pix(input int idx, input logic corners);
    rgb_pix_t p;
    p.sb.sof = rand_bits(1) != 0;
    p.sb.eol = rand_bits(1) != 0;
    p.r      = PIX_W'(rand_bits(PIX_W));
    p.g      = PIX_W'(rand_bits(PIX_W));
    p.b      = PIX_W'(rand_bits(PIX_W));
    if (corners && idx < 5) begin
      p.r = (idx == 1 || idx == 2) ? '1 : '0;
      p.g = (idx == 1 || idx == 3) ? '1 : '0;
      p.b = (idx == 1 || idx == 4) ? '1 : '0;
    end
    return p;
  endfunction

  // n words in, optional random gaps, out_ready and freeze stretches
  task automatic run_stream(input int n, input logic bp, input logic frz, input logic corners);
    int sent;
    int idle;
    int hold;
    sent = 0;
    idle = 0;
    hold = 0;
    while (sent < n || in_valid) begin
      @(posedge clk);
      #1;
      if (in_acc || !in_valid) begin
        idle = 0;
      end else begin
        idle++;
      end
      if (idle > WAIT_LIMIT) begin
        $display("timeout: input word was never accepted");
        abort_run();
      end
      if (hold > 0) begin
        hold--;
        if (hold == 0) begin
          en = 1'b1;
        end
      end else begin
        if (in_acc) begin
          in_valid = 1'b0;
        end
        if (!in_valid && sent < n && (!bp || rand_bits(2) != 0)) begin
          in_pix   = make_pix(sent, corners);
          in_valid = 1'b1;
          sent++;
        end
        if (bp) begin
          out_ready = rand_bits(1) != 0;
        end
        if (frz && rand_bits(3) == 0) begin
          en   = 1'b0;
          hold = int'(rand_bits(3)) + 1;
        end
      end
    end
    en = 1'b1;
  endtask

  // wait for every accepted word to come out, then compare counters
  task automatic drain_and_check();
    int i;
    out_ready = 1'b1;
    i = 0;
    while ((exp_q.size() != 0 || out_valid) && i < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      i++;
    end
    if (exp_q.size() != 0 || out_valid) begin
      $display("timeout: pipeline did not drain, %0d words missing", exp_q.size());
      abort_run();
    end
    check_eq(drop_cnt, 32'(drop_ref), "drop_cnt");
    check_eq(stall_cnt, 32'(stall_ref), "stall_cnt");
  endtask

  initial begin
    int i;
    clk       = 1'b0;
    rst       = 1'b1;
    en        = 1'b1;
    in_valid  = 1'b0;
    in_pix    = '0;
    out_ready = 1'b1;
    bypass    = 1'b0;
    clip      = '0;
    lfsr      = 32'h3928;

    // reset values
    repeat (4) @(posedge clk);
    #1;
    check_eq(32'(out_valid), 32'd0, "out_valid in reset");
    check_eq(32'(out_pix), 32'd0, "out_pix in reset");
    check_eq(32'(in_ready), 32'd0, "in_ready in reset");
    check_eq(drop_cnt, 32'd0, "drop_cnt in reset");
    check_eq(stall_cnt, 32'd0, "stall_cnt in reset");
    rst = 1'b0;
    i = 0;
    while (!in_ready && i < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      i++;
    end
    if (!in_ready) begin
      $display("timeout: in_ready never rose after reset");
      abort_run();
    end

    // plain conversion with corner pixels
    run_stream(300, 1'b0, 1'b0, 1'b1);
    drain_and_check();

    // ordinary window, lo <= hi
    clip.en = 1'b1;
    clip.lo = PIX_W'(rand_bits(9));
    clip.hi = clip.lo + PIX_W'(rand_bits(9));
    run_stream(200, 1'b0, 1'b0, 1'b0);
    drain_and_check();

    // inverted window, lo > hi
    clip.hi = PIX_W'(rand_bits(9));
    clip.lo = clip.hi + PIX_W'(1) + PIX_W'(rand_bits(9));
    run_stream(200, 1'b0, 1'b0, 1'b0);
    drain_and_check();

    // bypass with the window still on
    bypass = 1'b1;
    run_stream(200, 1'b0, 1'b0, 1'b1);
    drain_and_check();

    // random back-pressure
    bypass  = 1'b0;
    clip.en = 1'b0;
    run_stream(400, 1'b1, 1'b0, 1'b0);
    drain_and_check();

    // back-pressure with freeze stretches
    run_stream(300, 1'b1, 1'b1, 1'b0);
    drain_and_check();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/rgb2y_top.sv
// RGB to luma converter top, skid buffer then matrix then pack stage
// all links are ready/valid, en freezes the whole pipeline

`default_nettype none

module rgb2y_top
  import pix_pkg::*;
  import conv_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      en,
  input  wire logic      in_valid,
  input  wire rgb_pix_t  in_pix,
  output logic           in_ready,
  output logic           out_valid,
  output y_pix_t         out_pix,
  input  wire logic      out_ready,
  input  wire logic      bypass,
  input  wire clip_cfg_t clip,
  output logic [31:0]    drop_cnt,
  output logic [31:0]    stall_cnt
);

  // skid to matrix
  logic     s_valid;
  logic     s_ready;
  rgb_pix_t s_pix;
  // matrix to pack
  logic     w_valid;
  logic     w_ready;
  y_wide_t  w_pix;

  rgb_skid u_skid (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .in_valid (in_valid),
    .in_pix   (in_pix),
    .in_ready (in_ready),
    .s_valid  (s_valid),
    .s_pix    (s_pix),
    .s_ready  (s_ready),
    .drop_cnt (drop_cnt)
  );

  rgb2y_matrix u_matrix (
    .clk     (clk),
    .rst     (rst),
    .en      (en),
    .s_valid (s_valid),
    .s_pix   (s_pix),
    .s_ready (s_ready),
    .w_valid (w_valid),
    .w_pix   (w_pix),
    .w_ready (w_ready)
  );

  rgb2y_out_pack u_pack (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .w_valid   (w_valid),
    .w_pix     (w_pix),
    .w_ready   (w_ready),
    .bypass    (bypass),
    .clip      (clip),
    .out_valid (out_valid),
    .out_pix   (out_pix),
    .out_ready (out_ready),
    .stall_cnt (stall_cnt)
  );

endmodule

`default_nettype wire

//--- verilog/rgb2y_out_pack.sv
// output pack stage, wide luma down to 10 bits with rounding and clip
// one elastic register at the output, data forced to zero when not valid

`default_nettype none

module rgb2y_out_pack
  import pix_pkg::*;
  import conv_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      en,
  input  wire logic      w_valid,
  input  wire y_wide_t   w_pix,
  output logic           w_ready,
  input  wire logic      bypass,
  input  wire clip_cfg_t clip,
  output logic           out_valid,
  output y_pix_t         out_pix,
  input  wire logic      out_ready,
  output logic [31:0]    stall_cnt
);

  // guard bits below the output lsb
  localparam int unsigned DROP_W = YW_W - PIX_W;

  logic [YW_W-1:0]  y_rnd;
  logic [PIX_W-1:0] y_top;
  logic [PIX_W-1:0] y_round;
  logic [PIX_W-1:0] y_lo;
  logic [PIX_W-1:0] y_clip;
  y_pix_t           nxt;
  y_pix_t           pix_r;
  logic             ov;

  // ------------------------------------------------------------------------
  // pack logic
  // ------------------------------------------------------------------------

  always_comb begin
    // add half an output lsb, carry out cannot happen (max 4092 + 2)
    y_rnd   = w_pix.yw + (YW_W'(1) << (DROP_W - 1));
    y_round = y_rnd[YW_W-1 -: PIX_W];
    // plain truncation for bypass
    y_top   = w_pix.yw[YW_W-1 -: PIX_W];

    // lower bound first
    y_lo = y_round;
    if (y_round < clip.lo) begin
      y_lo = clip.lo;
    end
    // upper bound compared against the unclipped value and wins last,
    // so an inverted window gives hi above hi and lo below it
    y_clip = y_lo;
    if (y_round > clip.hi) begin
      y_clip = clip.hi;
    end

    nxt.sb = w_pix.sb;
    if (bypass) begin
      nxt.y = y_top;
    end else if (clip.en) begin
      nxt.y = y_clip;
    end else begin
      nxt.y = y_round;
    end
  end

  // ------------------------------------------------------------------------
  // elastic output register
  // ------------------------------------------------------------------------

  // take a new word when empty or when the current one leaves
  assign w_ready = en & (~ov | out_ready);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ov <= 1'b0;
    end else if (w_ready) begin
      ov <= w_valid;
    end
  end

  // clip and bypass are sampled here, with the word
  always_ff @(posedge clk) begin
    if (w_ready && w_valid) begin
      pix_r <= nxt;
    end
  end

  assign out_valid = ov;
  // luma and sideband both read as zero between words
  assign out_pix   = ov ? pix_r : '0;

  // ------------------------------------------------------------------------
  // stall counter
  // ------------------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stall_cnt <= 32'd0;
    end else if (en && out_valid && !out_ready) begin
      stall_cnt <= stall_cnt + 32'd1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rgb2y_matrix.sv
// luma matrix, weighted sum of r, g and b in two pipeline stages
// stage one multiplies, stage two adds and drops the fraction bits

`default_nettype none

module rgb2y_matrix
  import pix_pkg::*;
  import conv_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     en,
  input  wire logic     s_valid,
  input  wire rgb_pix_t s_pix,
  output logic          s_ready,
  output logic          w_valid,
  output y_wide_t       w_pix,
  input  wire logic     w_ready
);

  // products of stage one with their sideband
  typedef struct packed {
    pix_sb_t           sb;
    logic [PROD_W-1:0] pr;
    logic [PROD_W-1:0] pg;
    logic [PROD_W-1:0] pb;
  } prod_set_t;

  logic             adv;
  logic             v1;
  logic             v2;
  prod_set_t        st1;
  y_wide_t          st2;
  logic [SUM_W-1:0] sum;

  // ------------------------------------------------------------------------
  // stall control
  // ------------------------------------------------------------------------

  // both stages move together, only when the last one can hand off
  assign adv     = en & (~v2 | w_ready);
  assign s_ready = adv;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else if (adv) begin
      v1 <= s_valid;
      v2 <= v1;
    end
  end

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------

  // no carry out, weights add up to exactly 1.0
  assign sum = st1.pr + st1.pg + st1.pb;

  always_ff @(posedge clk) begin
    if (adv) begin
      // stage one
      st1.sb <= s_pix.sb;
      st1.pr <= PROD_W'(s_pix.r) * PROD_W'(COEF_R);
      st1.pg <= PROD_W'(s_pix.g) * PROD_W'(COEF_G);
      st1.pb <= PROD_W'(s_pix.b) * PROD_W'(COEF_B);
      // stage two, keep integer bits plus two guard bits
      st2.sb <= st1.sb;
      st2.yw <= sum[COEF_SHIFT +: YW_W];
    end
  end

  assign w_valid = v2;
  assign w_pix   = st2;

endmodule

`default_nettype wire

//--- verilog/rgb_skid.sv
// input skid buffer, two entries deep with a registered in_ready
// also counts cycles where the source offers a word that is refused

`default_nettype none

module rgb_skid
  import pix_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     en,
  input  wire logic     in_valid,
  input  wire rgb_pix_t in_pix,
  output logic          in_ready,
  output logic          s_valid,
  output rgb_pix_t      s_pix,
  input  wire logic     s_ready,
  output logic [31:0]   drop_cnt
);

  // fill level 0..2, entry m0 is the head
  logic [1:0] cnt;
  logic [1:0] cnt_nxt;
  logic       rdy_r;
  rgb_pix_t   m0;
  rgb_pix_t   m1;
  logic       push;
  logic       pop;

  // ready comes from a flop, gated by the freeze only
  assign in_ready = rdy_r & en;
  assign s_valid  = (cnt != 2'd0);
  assign s_pix    = m0;
  assign push     = in_valid & in_ready;
  // s_ready is already low while frozen
  assign pop      = s_valid & s_ready;

  always_comb begin
    cnt_nxt = cnt;
    if (push && !pop) begin
      cnt_nxt = cnt + 2'd1;
    end else if (pop && !push) begin
      cnt_nxt = cnt - 2'd1;
    end
  end

  // fill state and ready, low for one cycle after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt   <= 2'd0;
      rdy_r <= 1'b0;
    end else if (en) begin
      cnt   <= cnt_nxt;
      // stays high until the second entry is taken
      rdy_r <= (cnt_nxt != 2'd2);
    end
  end

  // entries, head refills from m1 or straight from the input
  always_ff @(posedge clk) begin
    if (pop) begin
      if (cnt == 2'd2) begin
        m0 <= m1;
      end else if (push) begin
        m0 <= in_pix;
      end
    end else if (push) begin
      if (cnt == 2'd0) begin
        m0 <= in_pix;
      end else begin
        m1 <= in_pix;
      end
    end
  end

  // refused offers
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      drop_cnt <= 32'd0;
    end else if (en && in_valid && !in_ready) begin
      drop_cnt <= drop_cnt + 32'd1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/conv_pkg.sv
// colour conversion constants and types for the luma matrix and pack stage
// BT.601 weights in Q8, wide luma word and the clip window

`default_nettype none

package conv_pkg;
  import pix_pkg::*;

  // weights sum to 256, so the weighted sum never grows past PROD_W
  localparam int unsigned COEF_W = 8;
  localparam logic [COEF_W-1:0] COEF_R = 8'd77;
  localparam logic [COEF_W-1:0] COEF_G = 8'd150;
  localparam logic [COEF_W-1:0] COEF_B = 8'd29;

  // one channel times one weight
  localparam int unsigned PROD_W = PIX_W + COEF_W;
  // sum of three products, max 1023*256 still fits in 18 bits
  localparam int unsigned SUM_W = PROD_W;
  // drop 6 fraction bits to get the wide luma
  localparam int unsigned COEF_SHIFT = 6;
  localparam int unsigned YW_W = SUM_W - COEF_SHIFT;

  // matrix output, 2 + 12 = 14 bits
  typedef struct packed {
    pix_sb_t         sb;
    logic [YW_W-1:0] yw;
  } y_wide_t;

  // programmable output window, 1 + 10 + 10 = 21 bits
  typedef struct packed {
    logic             en;
    logic [PIX_W-1:0] lo;
    logic [PIX_W-1:0] hi;
  } clip_cfg_t;

endpackage

`default_nettype wire

//--- verilog/pix_pkg.sv
// pixel stream types shared by every stage of the RGB to luma converter
// rgb words enter the pipeline and luma words leave it, both with sideband

`default_nettype none

package pix_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------

  // one colour channel, also the width of the output luma
  localparam int unsigned PIX_W = 10;

  // ------------------------------------------------------------------------
  // stream payloads
  // ------------------------------------------------------------------------

  // frame markers, travel untouched next to every pixel
  typedef struct packed {
    logic sof;
    logic eol;
  } pix_sb_t;

  // input word, 2 + 3*10 = 32 bits
  typedef struct packed {
    pix_sb_t          sb;
    logic [PIX_W-1:0] r;
    logic [PIX_W-1:0] g;
    logic [PIX_W-1:0] b;
  } rgb_pix_t;

  // output word, 2 + 10 = 12 bits
  typedef struct packed {
    pix_sb_t          sb;
    logic [PIX_W-1:0] y;
  } y_pix_t;

endpackage

`default_nettype wire
